//--- l1_cache.f
+incdir+.
cache_cfg_pkg.sv
cache_bus_pkg.sv
cache_array_if.sv
cache_array.sv
cache_lookup.sv
cache_ctrl.sv
l1_cache.sv
tb_l1_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the l1_cache testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Finished with errors"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f l1_cache.f --top-module tb_l1_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_l1_cache > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation PASSED"
exit 0

//--- tb_l1_cache_tests.svh
/* test sequences, included into the testbench module body
   every access waits for completion, flush only runs with the port idle */
`ifndef TB_L1_CACHE_TESTS_SVH
`define TB_L1_CACHE_TESTS_SVH

task automatic untouched_reads();
    for (int i = 0; i < 8; i++) begin
        read_at(32'h0000_0100 + word_t'(i * 12));   // miss, clean fetch
        read_at(32'h0000_0100 + word_t'(i * 12));   // same word again, now a hit
        compare_word("cpu_busy cycles on hit", word_t'(busy_cycles), 32'h0);
    end
endtask

// one word merged lane by lane, read back after every write
task automatic byte_lane_writes();
    for (int i = 0; i < 7; i++) begin
        write_at(32'h0000_0300, $urandom(), LEGAL_BE[i]);
        read_at(32'h0000_0300);
        compare_word("cpu_busy cycles on hit", word_t'(busy_cycles), 32'h0);
    end
endtask

task automatic dirty_evictions();
    word_t base;
    base = 32'h0000_2028;   // set 5, tag steps by 64 bytes
    for (int i = 0; i < 5; i++)
        write_at(base + word_t'(i * 64), $urandom(), 4'b1111);
    for (int i = 0; i < 5; i++)
        read_at(base + word_t'(i * 64));
endtask

task automatic flush_and_verify();
    @(negedge CLK);
    flush = 1'b1;
    n_issued++;
    @(negedge CLK);
    flush = 1'b0;
    @(posedge CLK);
    while (!flush_done)
        @(posedge CLK);
    @(posedge CLK);
    compare_word("flush_done", word_t'(flush_done), 32'h0);   // single-cycle pulse
    foreach (shadow[a])
        compare_word($sformatf("memory word %h", a), mem_word(a), shadow[a]);
    read_at(32'h0000_2028);   // refetched after invalidate
endtask

task automatic uncached_accesses();
    write_at(32'hF000_0010, 32'hDEAD_BEEF, 4'b1111);
    write_at(32'hF000_0010, 32'h0000_5A00, 4'b0010);
    read_at(32'hF000_0010);
    read_at(32'hF000_0100);   // never written
    write_at(32'hF000_0104, 32'h1234_5678, 4'b1100);
    read_at(32'hF000_0104);
endtask

task automatic random_traffic();
    word_t       addr;
    int unsigned idx;
    for (int n = 0; n < 400; n++) begin
        idx  = $urandom_range(63, 0);
        addr = 32'h0000_1000 + word_t'(idx * 4);   // 32 blocks, twice the capacity
        if ($urandom_range(1, 0) == 1)
            write_at(addr, $urandom(), LEGAL_BE[$urandom_range(6, 0)]);
        else
            read_at(addr);
    end
endtask

task automatic run_all_tests();
    untouched_reads();
    byte_lane_writes();
    dirty_evictions();
    flush_and_verify();
    uncached_accesses();
    random_traffic();
endtask

`endif

//--- tb_l1_cache.sv
/* testbench for l1_cache, memory answers after 1 to 3 busy cycles
   one processor request at a time, flush only while the processor port is idle */
`timescale 1ns/1ns

module tb_l1_cache;
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int       FLUSH_ALLOW = 8 * N_SETS * ASSOC;   // cycles for a full dirty walk
    localparam byte_en_t LEGAL_BE [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                          4'b0011, 4'b1100, 4'b1111};

    logic     CLK = 1'b0;
    logic     nRST;
    logic     cpu_ren, cpu_wen;
    word_t    cpu_addr, cpu_wdata, cpu_rdata;
    byte_en_t cpu_byte_en;
    logic     cpu_busy;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    mem_addr;
    block_t   mem_wdata, mem_rdata;
    byte_en_t mem_byte_en;
    logic     flush, flush_done;

    word_t       mem_store [word_t];   // memory model, word address keys
    word_t       shadow [word_t];      // expected contents after completed writes
    int unsigned wait_left;            // busy cycles left for the current transfer
    block_t      next_rdata;
    int unsigned n_issued = 0;
    int unsigned cycle_cnt = 0;
    int unsigned busy_cycles;          // rising edges the last request waited

    always #20 CLK = ~CLK;

    l1_cache l1_cache_i (
        .CLK (CLK), .nRST (nRST),
        .cpu_ren (cpu_ren), .cpu_wen (cpu_wen), .cpu_addr (cpu_addr),
        .cpu_wdata (cpu_wdata), .cpu_byte_en (cpu_byte_en),
        .cpu_rdata (cpu_rdata), .cpu_busy (cpu_busy),
        .mem_ren (mem_ren), .mem_wen (mem_wen), .mem_addr (mem_addr),
        .mem_wdata (mem_wdata), .mem_byte_en (mem_byte_en),
        .mem_rdata (mem_rdata), .mem_busy (mem_busy),
        .flush (flush), .flush_done (flush_done)
    );

    function automatic word_t word_base(input word_t addr);
        return {addr[31:2], 2'b00};
    endfunction

    function automatic word_t init_word(input word_t addr);
        return word_base(addr) ^ 32'hA5A5_A5A5;   // every word starts distinct
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input byte_en_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        return mem_store.exists(word_base(addr)) ? mem_store[word_base(addr)] : init_word(addr);
    endfunction

    // expected value of any word as the processor should see it
    function automatic word_t ref_word(input word_t addr);
        return shadow.exists(word_base(addr)) ? shadow[word_base(addr)] : init_word(addr);
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("[ERROR] at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic store_block(input word_t addr, input block_t data, input byte_en_t be);
        word_t a;
        a = word_base(addr);
        mem_store[a] = merge_bytes(mem_word(a), data[0], be);
        if (addr < NONCACHE_START)   // uncached writes carry lane 0 only
            mem_store[a + 32'd4] = merge_bytes(mem_word(a + 32'd4), data[1], be);
    endtask

    // memory model, samples the bus at the rising edge and answers at the falling edge
    always @(posedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (!mem_busy) begin
                if (mem_wen)
                    store_block(mem_addr, mem_wdata, mem_byte_en);
                wait_left = $urandom_range(3, 1);
            end else if (wait_left != 0) begin
                wait_left--;
            end
            next_rdata = {mem_word(mem_addr + 32'd4), mem_word(mem_addr)};
        end
    end

    always @(negedge CLK) begin
        mem_busy  = (wait_left != 0);
        mem_rdata = next_rdata;
    end

    // compare completed reads, track completed writes
    always @(posedge CLK) begin
        if (nRST && !cpu_busy) begin
            if (cpu_ren)
                compare_word("cpu_rdata", cpu_rdata, ref_word(cpu_addr));
            else if (cpu_wen)
                shadow[word_base(cpu_addr)] =
                    merge_bytes(ref_word(cpu_addr), cpu_wdata, cpu_byte_en);
        end
        if ((mem_ren || mem_wen) && mem_addr < NONCACHE_START)
            compare_word("mem_byte_en", word_t'(mem_byte_en), 32'h0000_000F);
        if ((cpu_ren || cpu_wen) && cpu_addr >= NONCACHE_START && (mem_ren || mem_wen)) begin
            compare_word("mem_addr", mem_addr, cpu_addr);
            compare_word("mem_ren", word_t'(mem_ren), word_t'(cpu_ren));
            compare_word("mem_wen", word_t'(mem_wen), word_t'(cpu_wen));
            compare_word("mem_byte_en", word_t'(mem_byte_en), word_t'(cpu_byte_en));
            if (cpu_wen)   // disabled lanes go out as zero
                compare_word("mem_wdata[0]", mem_wdata[0],
                             merge_bytes(32'h0, cpu_wdata, cpu_byte_en));
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > 64 * (n_issued + 1) + FLUSH_ALLOW)
            stop_on_failure($sformatf("timeout: no progress after %0d cycles", cycle_cnt));
    end

    task automatic cpu_transfer(input logic wr, input word_t addr, input word_t data,
                                input byte_en_t be);
        @(negedge CLK);
        cpu_ren     = !wr;
        cpu_wen     = wr;
        cpu_addr    = addr;
        cpu_wdata   = data;
        cpu_byte_en = be;
        n_issued++;
        busy_cycles = 0;
        @(posedge CLK);
        while (cpu_busy) begin   // held until the cache takes it
            busy_cycles++;
            @(posedge CLK);
        end
        @(negedge CLK);
        cpu_ren = 1'b0;
        cpu_wen = 1'b0;
    endtask

    task automatic read_at(input word_t addr);
        cpu_transfer(1'b0, addr, 32'h0, 4'b1111);
    endtask

    task automatic write_at(input word_t addr, input word_t data, input byte_en_t be);
        cpu_transfer(1'b1, addr, data, be);
    endtask

    `include "tb_l1_cache_tests.svh"

    initial begin
        void'($urandom(51657));
        nRST        = 1'b0;
        cpu_ren     = 1'b0;
        cpu_wen     = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_byte_en = '0;
        flush       = 1'b0;
        mem_busy    = 1'b1;
        mem_rdata   = '0;
        next_rdata  = '0;
        wait_left   = $urandom_range(3, 1);
        repeat (3) @(negedge CLK);
        nRST = 1'b1;
        run_all_tests();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- l1_cache.sv
/* two-way write-back L1 data cache, plain processor and memory ports
   processor holds a request until cpu_busy is low, no abort on either side */
`timescale 1ns/1ns

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    cpu_ren,
    input  logic                    cpu_wen,
    input  cache_bus_pkg::word_t    cpu_addr,
    input  cache_bus_pkg::word_t    cpu_wdata,
    input  cache_bus_pkg::byte_en_t cpu_byte_en,
    output cache_bus_pkg::word_t    cpu_rdata,
    output logic                    cpu_busy,
    output logic                    mem_ren,
    output logic                    mem_wen,
    output cache_bus_pkg::word_t    mem_addr,
    output cache_bus_pkg::block_t   mem_wdata,
    output cache_bus_pkg::byte_en_t mem_byte_en,
    input  cache_bus_pkg::block_t   mem_rdata,
    input  logic                    mem_busy,
    input  logic                    flush,
    output logic                    flush_done
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    logic       hit;
    way_t       hit_way;
    word_t      hit_word;
    logic       pass_through;
    way_t       victim_way;
    cache_tag_t victim_tag;
    logic       touch;
    way_t       touch_way;

    cache_array_if arr_if ();

    cache_array cache_array_i (
        .CLK (CLK),
        .arr (arr_if.array)
    );

    cache_lookup cache_lookup_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .arr          (arr_if.lookup),
        .req_addr     (cpu_addr),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .pass_through (pass_through),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag)
    );

    cache_ctrl cache_ctrl_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .arr          (arr_if.ctrl),
        .cpu_ren      (cpu_ren),
        .cpu_wen      (cpu_wen),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_byte_en  (cpu_byte_en),
        .cpu_rdata    (cpu_rdata),
        .cpu_busy     (cpu_busy),
        .flush        (flush),
        .flush_done   (flush_done),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .pass_through (pass_through),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .touch        (touch),
        .touch_way    (touch_way)
    );

endmodule

//--- cache_ctrl.sv
/* one request at a time, the processor holds it until cpu_busy is low
   a write miss fetches clean and then completes as a write hit */
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                       CLK,
    input  logic                       nRST,
    cache_array_if.ctrl                arr,
    input  logic                       cpu_ren,
    input  logic                       cpu_wen,
    input  cache_cfg_pkg::cache_addr_t cpu_addr,
    input  cache_bus_pkg::word_t       cpu_wdata,
    input  cache_bus_pkg::byte_en_t    cpu_byte_en,
    output cache_bus_pkg::word_t       cpu_rdata,
    output logic                       cpu_busy,
    input  logic                       flush,
    output logic                       flush_done,
    output logic                       mem_ren,
    output logic                       mem_wen,
    output cache_bus_pkg::word_t       mem_addr,
    output cache_bus_pkg::block_t      mem_wdata,
    output cache_bus_pkg::byte_en_t    mem_byte_en,
    input  cache_bus_pkg::block_t      mem_rdata,
    input  logic                       mem_busy,
    input  logic                       hit,
    input  cache_cfg_pkg::way_t        hit_way,
    input  cache_bus_pkg::word_t       hit_word,
    input  logic                       pass_through,
    input  cache_cfg_pkg::way_t        victim_way,
    input  cache_cfg_pkg::cache_tag_t  victim_tag,
    output logic                       touch,
    output cache_cfg_pkg::way_t        touch_way
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    cache_state_t state, next_state;
    logic         flush_req;       // flush seen, not yet done
    logic         flush_pend;
    logic         cpu_req;
    set_idx_t     fl_set;          // shared by the reset clear and the flush walk
    way_t         fl_way;
    logic         fl_last;
    logic         idle_step;
    logic         fl_step;
    word_t        lane_mask;
    cache_frame_t fl_frame;

    assign cpu_req    = cpu_ren || cpu_wen;
    assign flush_pend = flush || flush_req;
    assign fl_last    = (fl_set == set_idx_t'(N_SETS - 1)) && (fl_way == way_t'(ASSOC - 1));
    assign fl_frame   = arr.rdata.frames[fl_way];
    assign lane_mask  = {{8{cpu_byte_en[3]}}, {8{cpu_byte_en[2]}},
                         {8{cpu_byte_en[1]}}, {8{cpu_byte_en[0]}}};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_req <= 1'b0;
            fl_set    <= '0;
            fl_way    <= '0;
        end else begin
            state     <= next_state;
            flush_req <= flush_pend && !flush_done;
            if (idle_step)
                fl_set <= fl_set + 1'b1;
            else if (fl_step)
                {fl_set, fl_way} <= {fl_set, fl_way} + 1'b1;   // way first, then set
        end
    end

    always_comb begin
        next_state  = state;
        arr.sel     = cpu_addr.idx;
        arr.wen     = 1'b0;
        arr.wdata   = '0;
        arr.wmask   = '1;
        cpu_busy    = 1'b1;
        cpu_rdata   = '0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_byte_en = '1;       // block transfers move every byte
        touch       = 1'b0;
        touch_way   = hit_way;
        flush_done  = 1'b0;
        idle_step   = 1'b0;
        fl_step     = 1'b0;

        case (state)
            IDLE: begin
                arr.sel   = fl_set;
                arr.wen   = 1'b1;
                arr.wmask = '0;   // wipe the whole set
                idle_step = 1'b1;
                if (fl_set == set_idx_t'(N_SETS - 1))
                    next_state = HIT;
            end
            HIT: begin
                if (cpu_req && pass_through) begin
                    // straight to memory, word sits in lane 0
                    mem_ren      = cpu_ren;
                    mem_wen      = cpu_wen;
                    mem_addr     = cpu_addr;
                    mem_byte_en  = cpu_byte_en;
                    mem_wdata[0] = cpu_wdata & lane_mask;
                    cpu_busy     = mem_busy;
                    cpu_rdata    = mem_rdata[0];
                end else if (flush_pend) begin
                    next_state = FLUSH;
                end else if (cpu_req && hit) begin
                    cpu_busy = 1'b0;
                    touch    = 1'b1;
                    if (cpu_ren)
                        cpu_rdata = hit_word;
                    if (cpu_wen) begin
                        arr.wen = 1'b1;
                        arr.wdata.frames[hit_way].data[cpu_addr.blk] = cpu_wdata;
                        arr.wmask.frames[hit_way].data[cpu_addr.blk] = ~lane_mask;
                        arr.wdata.frames[hit_way].tag.dirty = 1'b1;
                        arr.wmask.frames[hit_way].tag.dirty = 1'b0;
                    end
                end else if (cpu_req) begin
                    next_state = (victim_tag.valid && victim_tag.dirty) ? WB : FETCH;
                end
            end
            WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag.tag_bits, cpu_addr.idx, {N_BLOCK_BITS{1'b0}}, 2'b00};
                mem_wdata = arr.rdata.frames[victim_way].data;
                if (!mem_busy) begin
                    arr.wen = 1'b1;   // victim gone, wdata already zero
                    arr.wmask.frames[victim_way].tag.valid = 1'b0;
                    arr.wmask.frames[victim_way].tag.dirty = 1'b0;
                    next_state = FETCH;
                end
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {cpu_addr.tag, cpu_addr.idx, {N_BLOCK_BITS{1'b0}}, 2'b00};
                if (!mem_busy) begin
                    arr.wen = 1'b1;
                    arr.wdata.frames[victim_way].tag.valid    = 1'b1;
                    arr.wdata.frames[victim_way].tag.tag_bits = cpu_addr.tag;
                    arr.wdata.frames[victim_way].data         = mem_rdata;
                    arr.wmask.frames[victim_way]              = '0;   // filled clean
                    next_state = HIT;
                end
            end
            FLUSH: begin
                arr.sel = fl_set;
                if (fl_frame.tag.valid && fl_frame.tag.dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {fl_frame.tag.tag_bits, fl_set, {N_BLOCK_BITS{1'b0}}, 2'b00};
                    mem_wdata = fl_frame.data;
                    fl_step   = !mem_busy;   // wait for the write-back
                end else begin
                    fl_step = 1'b1;
                end
                if (fl_step) begin
                    arr.wen                   = 1'b1;
                    arr.wmask.frames[fl_way]  = '0;
                end
                if (fl_step && fl_last) begin
                    flush_done = 1'b1;
                    next_state = HIT;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // only one transfer on the memory bus at a time
    a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("cache_ctrl: mem_ren and mem_wen both high");

    a_idle_busy: assert property (@(posedge CLK) disable iff (!nRST)
        state == IDLE |-> cpu_busy)
        else $error("cache_ctrl: request completed during array clear");

endmodule

//--- cache_lookup.sv
/* tag compare on the set currently selected in the array
   victim is the way after the most recently used one of that set */
`timescale 1ns/1ns

module cache_lookup (
    input  logic                      CLK,
    input  logic                      nRST,
    cache_array_if.lookup             arr,
    input  cache_cfg_pkg::cache_addr_t req_addr,
    input  logic                      touch,
    input  cache_cfg_pkg::way_t       touch_way,
    output logic                      hit,
    output cache_cfg_pkg::way_t       hit_way,
    output cache_bus_pkg::word_t      hit_word,
    output logic                      pass_through,
    output cache_cfg_pkg::way_t       victim_way,
    output cache_cfg_pkg::cache_tag_t victim_tag
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    logic [ASSOC-1:0]  match;
    way_t [N_SETS-1:0] mru;    // most recently used way, per set

    assign pass_through = req_addr >= NONCACHE_START;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < ASSOC; i++) begin
            match[i] = arr.rdata.frames[i].tag.valid &&
                       (arr.rdata.frames[i].tag.tag_bits == req_addr.tag);
            if (match[i])
                hit_way = way_t'(i);
        end
    end

    assign hit      = (|match) && !pass_through;   // uncached space never hits
    assign hit_word = arr.rdata.frames[hit_way].data[req_addr.blk];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mru <= '0;
        end else if (touch) begin
            mru[arr.sel] <= touch_way;
        end
    end

    assign victim_way = mru[arr.sel] + 1'b1;   // wraps with two ways
    assign victim_tag = arr.rdata.frames[victim_way].tag;

    // fills always go to the victim, so a tag lives in one way only
    a_one_match: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(match) |-> $onehot0(match))
        else $error("cache_lookup: tag present in more than one way");

endmodule

//--- cache_array.sv
/* set-indexed storage, contents undefined until the controller clears it
   read is combinational, write lands on the rising edge under wmask */
`timescale 1ns/1ns

module cache_array (
    input logic          CLK,
    cache_array_if.array arr
);
    import cache_cfg_pkg::*;

    cache_set_t sets [N_SETS];
    cache_set_t cur_set;
    cache_set_t new_set;

    assign cur_set = sets[arr.sel];

    // masked merge, 0 in wmask takes wdata
    assign new_set = (cur_set & arr.wmask) | (arr.wdata & ~arr.wmask);

    always_ff @(posedge CLK) begin
        if (arr.wen) begin
            sets[arr.sel] <= new_set;
        end
    end

    assign arr.rdata = cur_set;

    // controller must always point at a real set when writing
    a_sel_known: assert property (@(posedge CLK) arr.wen |-> !$isunknown(arr.sel))
        else $error("cache_array: write with unknown set select");

endmodule

//--- cache_array_if.sv
/* one set-wide port into the cache array
   wmask bit high keeps the stored bit, rdata follows sel in the same cycle */
`timescale 1ns/1ns

interface cache_array_if;
    import cache_cfg_pkg::*;

    set_idx_t   sel;    // set being read and written
    logic       wen;
    cache_set_t wdata;
    cache_set_t wmask;
    cache_set_t rdata;

    modport ctrl (
        output sel, wen, wdata, wmask,
        input  rdata
    );

    modport array (
        input  sel, wen, wdata, wmask,
        output rdata
    );

    // tag compare and victim tracking only look
    modport lookup (
        input sel, rdata
    );

endinterface

//--- cache_bus_pkg.sv
/* processor and memory bus types, plus controller states
   everything at or above NONCACHE_START bypasses the cache */
package cache_bus_pkg;

    typedef logic [cache_cfg_pkg::WORD_BITS-1:0] word_t;
    typedef word_t [cache_cfg_pkg::BLOCK_WORDS-1:0] block_t;   // one memory transfer
    typedef logic [3:0] byte_en_t;                               // one bit per byte lane

    localparam word_t NONCACHE_START = 32'hF000_0000;

    // controller states
    typedef enum logic [2:0] {
        IDLE,   // post-reset clear
        HIT,    // serving requests
        FETCH,  // block read from memory
        WB,     // dirty victim written back
        FLUSH   // walking every frame
    } cache_state_t;

endpackage

//--- cache_cfg_pkg.sv
/* geometry is fixed at 128 bytes, 2-way, 2-word blocks, 8 sets
   byte addressing with 32-bit words, all sizes powers of two */
package cache_cfg_pkg;

    localparam int WORD_BITS    = 32;
    localparam int CACHE_BYTES  = 128;   // data only, tags not counted
    localparam int BLOCK_WORDS  = 2;
    localparam int ASSOC        = 2;
    localparam int N_SETS       = CACHE_BYTES / (4 * BLOCK_WORDS * ASSOC);

    // address field widths
    localparam int N_SET_BITS   = 3;
    localparam int N_BLOCK_BITS = 1;
    localparam int N_TAG_BITS   = WORD_BITS - N_SET_BITS - N_BLOCK_BITS - 2;
    localparam int N_WAY_BITS   = 1;

    typedef logic [N_WAY_BITS-1:0] way_t;
    typedef logic [N_SET_BITS-1:0] set_idx_t;

    // processor address as the cache sees it
    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        set_idx_t                idx;
        logic [N_BLOCK_BITS-1:0] blk;   // word within block
        logic [1:0]              off;   // byte offset, ignored
    } cache_addr_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [N_TAG_BITS-1:0] tag_bits;
    } cache_tag_t;

    typedef struct packed {
        cache_tag_t                             tag;
        logic [BLOCK_WORDS-1:0][WORD_BITS-1:0]  data;
    } cache_frame_t;

    // one row of the array, all ways side by side
    typedef struct packed {
        cache_frame_t [ASSOC-1:0] frames;
    } cache_set_t;

endpackage
